/* verilog/hiq_pkg.sv */
// layout fixed to a 48-bit TSN tag and 9-bit buffer id; FIFO_DEPTH must be a power of two matching FIFO_AW
package hiq_pkg;

    //**********************************************************************
    // descriptor layouts
    //**********************************************************************

    // offer from one descriptor source, held until ack
    typedef struct packed {
        logic [47:0] tsn_tag;
        logic [8:0]  buf_id;
        logic        lookup_flag;
    } hiq_req_t;

    // queue entry, flag on top and buffer id at the bottom
    typedef struct packed {
        logic        lookup_flag;
        logic [11:0] flow_id;
        logic [8:0]  buf_id;
    } hiq_desc_t;

    // flow id field inside the tag
    localparam int FLOWID_MSB = 42;
    localparam int FLOWID_LSB = 31;

    //**********************************************************************
    // queue sizing
    //**********************************************************************

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    // one wider than the pointer so a full queue can be counted
    localparam int FIFO_CW    = 5;

    //**********************************************************************
    // host register map
    //**********************************************************************

    localparam int WB_DW = 32;
    localparam int WB_AW = 4;

    localparam logic [WB_AW-1:0] REG_DESC   = 4'd0;
    localparam logic [WB_AW-1:0] REG_STATUS = 4'd1;

    // status word carries the count in the low bits
    localparam int DESC_VALID_BIT  = 31;
    localparam int STATUS_FULL_BIT = 8;

endpackage

/* verilog/host_input_queue.sv */
// sources must hold request and wr until ack and then drop wr; hcp can starve network while it keeps requesting
`timescale 1ns/1ps

module host_input_queue (
    input  logic               i_clk,
    input  logic               i_rst_n,

    // host control port
    input  hiq_pkg::hiq_req_t  i_hcp_req,
    input  logic               i_hcp_wr,
    output logic               o_hcp_ack,

    // network side
    input  hiq_pkg::hiq_req_t  i_net_req,
    input  logic               i_net_wr,
    output logic               o_net_ack,

    // queue write side
    input  logic               i_fifo_full,
    output logic               o_fifo_wr,
    output hiq_pkg::hiq_desc_t o_fifo_wdata
);

    typedef enum logic [1:0] {
        IDLE_S      = 2'd0,
        HCP_PAUSE_S = 2'd1,
        NET_PAUSE_S = 2'd2
    } arb_state_t;

    arb_state_t state;
    logic       grant_hcp;
    logic       grant_net;

    // flag, flow id from the tag, buffer id
    function automatic hiq_pkg::hiq_desc_t pack_entry(input hiq_pkg::hiq_req_t req);
        hiq_pkg::hiq_desc_t entry;
        entry.lookup_flag = req.lookup_flag;
        entry.flow_id     = req.tsn_tag[hiq_pkg::FLOWID_MSB:hiq_pkg::FLOWID_LSB];
        entry.buf_id      = req.buf_id;
        return entry;
    endfunction

    //**********************************************************************
    // grant decision
    //**********************************************************************

    // hcp first, network only while hcp is quiet
    assign grant_hcp = (state == IDLE_S) && !i_fifo_full && i_hcp_wr;
    assign grant_net = (state == IDLE_S) && !i_fifo_full && !i_hcp_wr && i_net_wr;

    //**********************************************************************
    // arbiter FSM
    //**********************************************************************

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= IDLE_S;
            o_hcp_ack <= 1'b0;
            o_net_ack <= 1'b0;
            o_fifo_wr <= 1'b0;
        end else begin
            // strobes last one cycle
            o_hcp_ack <= 1'b0;
            o_net_ack <= 1'b0;
            o_fifo_wr <= 1'b0;
            case (state)
                IDLE_S: begin
                    if (grant_hcp) begin
                        o_hcp_ack <= 1'b1;
                        o_fifo_wr <= 1'b1;
                        state     <= HCP_PAUSE_S;
                    end else if (grant_net) begin
                        o_net_ack <= 1'b1;
                        o_fifo_wr <= 1'b1;
                        state     <= NET_PAUSE_S;
                    end
                end
                // wait for the served source to release wr
                HCP_PAUSE_S: begin
                    if (!i_hcp_wr) begin
                        state <= IDLE_S;
                    end
                end
                NET_PAUSE_S: begin
                    if (!i_net_wr) begin
                        state <= IDLE_S;
                    end
                end
                default: begin
                    state <= IDLE_S;
                end
            endcase
        end
    end

    // entry goes out with the write strobe
    always_ff @(posedge i_clk) begin
        if (grant_hcp) begin
            o_fifo_wdata <= pack_entry(i_hcp_req);
        end else if (grant_net) begin
            o_fifo_wdata <= pack_entry(i_net_req);
        end
    end

endmodule

/* verilog/descriptor_fifo.sv */
// writer must not write when full and reader must not pop when empty; neither is checked here
`timescale 1ns/1ps

module descriptor_fifo (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // write side
    input  logic                        i_wr,
    input  hiq_pkg::hiq_desc_t          i_wdata,

    // read side, head visible before the pop
    input  logic                        i_pop,
    output hiq_pkg::hiq_desc_t          o_head,

    // occupancy
    output logic                        o_empty,
    output logic                        o_full,
    output logic [hiq_pkg::FIFO_CW-1:0] o_count
);

    hiq_pkg::hiq_desc_t          mem [hiq_pkg::FIFO_DEPTH];
    logic [hiq_pkg::FIFO_AW-1:0] wr_ptr;
    logic [hiq_pkg::FIFO_AW-1:0] rd_ptr;
    logic [hiq_pkg::FIFO_CW-1:0] count;

    //**********************************************************************
    // storage
    //**********************************************************************

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    // first word fall through
    assign o_head = mem[rd_ptr];

    //**********************************************************************
    // pointers and count
    //**********************************************************************

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_wr, i_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                // write and pop together leave the count alone
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign o_count = count;
    assign o_empty = (count == '0);
    assign o_full  = (count == hiq_pkg::FIFO_CW'(hiq_pkg::FIFO_DEPTH));

endmodule

/* verilog/host_queue_wb.sv */
// Wishbone classic slave, no wait on the master beyond one cycle; writes are acked and dropped, no sel or err
`timescale 1ns/1ps

module host_queue_wb (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // host bus
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [hiq_pkg::WB_AW-1:0]   i_wb_adr,
    // write data has no register to land in
    input  logic [hiq_pkg::WB_DW-1:0]   i_wb_dat,
    output logic [hiq_pkg::WB_DW-1:0]   o_wb_dat,
    output logic                        o_wb_ack,

    // queue head and status
    input  hiq_pkg::hiq_desc_t          i_head,
    input  logic                        i_empty,
    input  logic                        i_full,
    input  logic [hiq_pkg::FIFO_CW-1:0] i_count,

    output logic                        o_pop
);

    logic                      access_start;
    logic                      desc_sel;
    logic                      status_sel;
    logic [hiq_pkg::WB_DW-1:0] rd_word;

    //**********************************************************************
    // decode
    //**********************************************************************

    // new cycle seen, not yet acked
    assign access_start = i_wb_cyc && i_wb_stb && !o_wb_ack;

    assign desc_sel   = (i_wb_adr == hiq_pkg::REG_DESC);
    assign status_sel = (i_wb_adr == hiq_pkg::REG_STATUS);

    // pop lands on the same clock that raises ack
    assign o_pop = access_start && !i_wb_we && desc_sel && !i_empty;

    //**********************************************************************
    // read word
    //**********************************************************************

    always_comb begin
        rd_word = '0;
        if (desc_sel && !i_empty) begin
            rd_word[hiq_pkg::DESC_VALID_BIT]         = 1'b1;
            rd_word[$bits(hiq_pkg::hiq_desc_t)-1:0]  = i_head;
        end else if (status_sel) begin
            rd_word[hiq_pkg::FIFO_CW-1:0]     = i_count;
            rd_word[hiq_pkg::STATUS_FULL_BIT] = i_full;
        end
    end

    // empty queue and unmapped addresses read as zero
    always_ff @(posedge i_clk) begin
        if (access_start) begin
            if (i_wb_we) begin
                o_wb_dat <= '0;
            end else begin
                o_wb_dat <= rd_word;
            end
        end
    end

    //**********************************************************************
    // ack
    //**********************************************************************

    // one cycle only, master drops stb after it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access_start;
        end
    end

endmodule

/* verilog/host_rx_subsystem.sv */
// queue holds FIFO_DEPTH entries; descriptor sources stall without limit while it is full
`timescale 1ns/1ps

module host_rx_subsystem (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // host control port
    input  hiq_pkg::hiq_req_t           i_hcp_req,
    input  logic                        i_hcp_wr,
    output logic                        o_hcp_ack,

    // network side
    input  hiq_pkg::hiq_req_t           i_net_req,
    input  logic                        i_net_wr,
    output logic                        o_net_ack,

    // host bus
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [hiq_pkg::WB_AW-1:0]   i_wb_adr,
    input  logic [hiq_pkg::WB_DW-1:0]   i_wb_dat,
    output logic [hiq_pkg::WB_DW-1:0]   o_wb_dat,
    output logic                        o_wb_ack
);

    // arbiter to queue
    logic                        fifo_wr;
    hiq_pkg::hiq_desc_t          fifo_wdata;
    logic                        fifo_full;

    // queue to host slave
    hiq_pkg::hiq_desc_t          fifo_head;
    logic                        fifo_empty;
    logic [hiq_pkg::FIFO_CW-1:0] fifo_count;
    logic                        fifo_pop;

    host_input_queue host_input_queue_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_hcp_req    (i_hcp_req),
        .i_hcp_wr     (i_hcp_wr),
        .o_hcp_ack    (o_hcp_ack),
        .i_net_req    (i_net_req),
        .i_net_wr     (i_net_wr),
        .o_net_ack    (o_net_ack),
        .i_fifo_full  (fifo_full),
        .o_fifo_wr    (fifo_wr),
        .o_fifo_wdata (fifo_wdata)
    );

    descriptor_fifo descriptor_fifo_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (fifo_wr),
        .i_wdata (fifo_wdata),
        .i_pop   (fifo_pop),
        .o_head  (fifo_head),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_count (fifo_count)
    );

    host_queue_wb host_queue_wb_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_head   (fifo_head),
        .i_empty  (fifo_empty),
        .i_full   (fifo_full),
        .i_count  (fifo_count),
        .o_pop    (fifo_pop)
    );

endmodule

/* sim/tb_clkgen.sv */
// fixed 20 ns clock; reset held low for two rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD_NS = 10;

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        // release away from the active edge
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

    always #HALF_PERIOD_NS o_clk = ~o_clk;

endmodule

/* sim/tb_host_rx_subsystem.sv */
// stimulus changes on falling edges and results are sampled there; the first failed check ends the run
`timescale 1ns/1ps

module tb_host_rx_subsystem;

    localparam int ACK_LIMIT     = 40;
    localparam int RANDOM_OFFERS = 40;
    localparam int DIRECTED_TXNS = 80;
    localparam int TXN_COUNT     = DIRECTED_TXNS + 2 * RANDOM_OFFERS;
    localparam int WATCHDOG_CYCLES = TXN_COUNT * 40 + 200;

    logic                          clk;
    logic                          rst_n;
    hiq_pkg::hiq_req_t             hcp_req;
    logic                          hcp_wr;
    logic                          hcp_ack;
    hiq_pkg::hiq_req_t             net_req;
    logic                          net_wr;
    logic                          net_ack;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [hiq_pkg::WB_AW-1:0]     wb_adr;
    logic [hiq_pkg::WB_DW-1:0]     wb_dat_w;
    logic [hiq_pkg::WB_DW-1:0]     wb_dat_r;
    logic                          wb_ack;

    // entries in the order the arbiter accepted them
    hiq_pkg::hiq_desc_t            model_q[$];
    integer                        seed = 39;
    int                            error_count = 0;

    tb_clkgen tb_clkgen_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    host_rx_subsystem host_rx_subsystem_inst (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_hcp_req (hcp_req),
        .i_hcp_wr  (hcp_wr),
        .o_hcp_ack (hcp_ack),
        .i_net_req (net_req),
        .i_net_wr  (net_wr),
        .o_net_ack (net_ack),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_adr  (wb_adr),
        .i_wb_dat  (wb_dat_w),
        .o_wb_dat  (wb_dat_r),
        .o_wb_ack  (wb_ack)
    );

    //**********************************************************************
    // error reporting
    //**********************************************************************

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("[FAIL] time %0t: %s read %h, expected %h", $time, what, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("error at time %0t: %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    //**********************************************************************
    // model
    //**********************************************************************

    // flag on top, flow id from the tag, buffer id at the bottom
    function automatic hiq_pkg::hiq_desc_t expected_entry(input hiq_pkg::hiq_req_t req);
        return {req.lookup_flag, req.tsn_tag[hiq_pkg::FLOWID_MSB:hiq_pkg::FLOWID_LSB],
                req.buf_id};
    endfunction

    function automatic hiq_pkg::hiq_req_t random_req();
        hiq_pkg::hiq_req_t req;
        logic [63:0]       bits;
        bits            = {$random(seed), $random(seed)};
        req.tsn_tag     = bits[47:0];
        req.buf_id      = bits[56:48];
        req.lookup_flag = bits[57];
        return req;
    endfunction

    //**********************************************************************
    // protocol properties
    //**********************************************************************

    wb_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else report_error("wishbone ack stayed high for two cycles");
    hcp_ack_single: assert property (@(posedge clk) disable iff (!rst_n) hcp_ack |=> !hcp_ack)
        else report_error("hcp ack stayed high for two cycles");
    net_ack_single: assert property (@(posedge clk) disable iff (!rst_n) net_ack |=> !net_ack)
        else report_error("network ack stayed high for two cycles");
    one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(hcp_ack && net_ack))
        else report_error("both descriptor ports acked in one cycle");

    //**********************************************************************
    // stimulus tasks
    //**********************************************************************

    // hold request and wr until ack, then keep wr for hold_cycles more
    task automatic offer_descriptor(input bit use_net, input hiq_pkg::hiq_req_t req,
                                    input int hold_cycles);
        int waited;
        bit acked;
        @(negedge clk);
        if (use_net) begin
            net_req = req;
            net_wr  = 1'b1;
        end else begin
            hcp_req = req;
            hcp_wr  = 1'b1;
        end
        waited = 0;
        acked  = 1'b0;
        while (!acked) begin
            @(negedge clk);
            waited++;
            acked = use_net ? net_ack : hcp_ack;
            if (!acked && waited > ACK_LIMIT) begin
                report_error("descriptor offer was never acknowledged");
            end
        end
        // accepted entries join the model in ack order
        model_q.push_back(expected_entry(req));
        repeat (hold_cycles) @(negedge clk);
        if (use_net) begin
            net_wr = 1'b0;
        end else begin
            hcp_wr = 1'b0;
        end
    endtask

    task automatic wb_access(input logic we, input logic [hiq_pkg::WB_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
            if (!wb_ack && waited > ACK_LIMIT) begin
                report_error("wishbone slave never acknowledged the access");
            end
        end while (!wb_ack);
        assert (waited == 1) else report_error("wishbone ack came later than one cycle");
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        assert (!wb_ack) else report_error("wishbone gave a second ack for one access");
    endtask

    task automatic read_and_check_desc();
        logic [31:0]        got;
        logic [31:0]        exp;
        hiq_pkg::hiq_desc_t entry;
        assert (model_q.size() > 0) else report_error("descriptor read with nothing queued");
        entry = model_q.pop_front();
        exp   = {1'b1, 9'b0, entry};
        wb_access(1'b0, hiq_pkg::REG_DESC, 32'h0, got);
        assert (got == exp) else report_mismatch("descriptor register", got, exp);
    endtask

    task automatic check_status(input int exp_count, input bit exp_full);
        logic [31:0] got;
        logic [31:0] exp;
        exp      = '0;
        exp[4:0] = exp_count[4:0];
        exp[hiq_pkg::STATUS_FULL_BIT] = exp_full;
        wb_access(1'b0, hiq_pkg::REG_STATUS, 32'h0, got);
        assert (got == exp) else report_mismatch("status register", got, exp);
    endtask

    //**********************************************************************
    // test sequence
    //**********************************************************************

    initial begin
        hiq_pkg::hiq_req_t req_a;
        hiq_pkg::hiq_req_t req_b;
        logic [31:0]       rdata;
        int                offers;
        int                action;
        hcp_req  = '0;
        hcp_wr   = 1'b0;
        net_req  = '0;
        net_wr   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        @(posedge rst_n);
        @(negedge clk);
        assert (!hcp_ack && !net_ack && !wb_ack) else report_error("outputs busy after reset");
        check_status(0, 1'b0);

        // single hcp descriptor
        req_a = '{tsn_tag: 48'h0123_4567_89AB, buf_id: 9'h15A, lookup_flag: 1'b1};
        offer_descriptor(1'b0, req_a, 0);
        read_and_check_desc();
        check_status(0, 1'b0);

        // both ports in the same cycle, hcp first
        req_a = random_req();
        req_b = random_req();
        fork
            offer_descriptor(1'b0, req_a, 0);
            offer_descriptor(1'b1, req_b, 0);
        join
        assert (model_q.size() == 2 && model_q[0] == expected_entry(req_a))
            else report_error("network was acked before hcp");
        read_and_check_desc();
        read_and_check_desc();

        // wr held long after ack is queued once
        offer_descriptor(1'b1, random_req(), 12);
        check_status(1, 1'b0);
        read_and_check_desc();

        // fill the queue, then stall one request until a read frees a slot
        for (int i = 0; i < hiq_pkg::FIFO_DEPTH; i++) begin
            offer_descriptor(i[0], random_req(), 0);
        end
        check_status(hiq_pkg::FIFO_DEPTH, 1'b1);
        fork
            offer_descriptor(1'b0, random_req(), 0);
            begin
                repeat (8) begin
                    @(negedge clk);
                    assert (!hcp_ack) else report_error("request acked while the queue was full");
                end
                read_and_check_desc();
            end
        join
        check_status(hiq_pkg::FIFO_DEPTH, 1'b1);
        while (model_q.size() > 0) begin
            read_and_check_desc();
        end
        check_status(0, 1'b0);

        // empty read and ignored writes
        wb_access(1'b0, hiq_pkg::REG_DESC, 32'h0, rdata);
        assert (rdata == 32'h0) else report_mismatch("empty descriptor read", rdata, 32'h0);
        check_status(0, 1'b0);
        offer_descriptor(1'b0, random_req(), 0);
        wb_access(1'b1, hiq_pkg::REG_DESC, 32'hFFFF_FFFF, rdata);
        wb_access(1'b1, hiq_pkg::REG_STATUS, 32'hFFFF_FFFF, rdata);
        check_status(1, 1'b0);
        read_and_check_desc();
        check_status(0, 1'b0);

        // random mix of offers and reads
        offers = 0;
        while (offers < RANDOM_OFFERS) begin
            action = {$random(seed)} % 4;
            if (model_q.size() >= hiq_pkg::FIFO_DEPTH - 1) begin
                action = 3;
            end
            if (action == 2 && offers <= RANDOM_OFFERS - 2) begin
                req_a = random_req();
                req_b = random_req();
                fork
                    offer_descriptor(1'b0, req_a, {$random(seed)} % 3);
                    offer_descriptor(1'b1, req_b, {$random(seed)} % 3);
                join
                offers += 2;
            end else if (action == 3) begin
                if (model_q.size() > 0) begin
                    read_and_check_desc();
                end
            end else begin
                offer_descriptor(action == 1, random_req(), {$random(seed)} % 3);
                offers++;
            end
        end
        check_status(model_q.size(), model_q.size() == hiq_pkg::FIFO_DEPTH);
        while (model_q.size() > 0) begin
            read_and_check_desc();
        end
        check_status(0, 1'b0);

        if (error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // budget of 40 cycles per transaction plus margin
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

/* src.f */
verilog/hiq_pkg.sv
verilog/host_input_queue.sv
verilog/descriptor_fifo.sv
verilog/host_queue_wb.sv
verilog/host_rx_subsystem.sv
sim/tb_clkgen.sv
sim/tb_host_rx_subsystem.sv

/* Makefile */
# Verilator build and run of the host input queue testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_host_rx_subsystem
FILELIST = src.f
MDIR     = obj_dir

.PHONY: sim clean

# the simulator exit status carries pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
